//--- design/clint_timer.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module clint_timer (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             arvalid,
    input  logic [31:0]      araddr,
    output logic             arready,
    output lsu_pkg::rd_rsp_t rd
);

    logic [63:0] mtime;
    logic        rvalid_q;
    logic [31:0] rdata_q;
    logic        rerr_q;
    logic        hit_lo;
    logic        hit_hi;

    assign hit_lo = (araddr == `LSU_CLINT_BASE + `LSU_MTIME_LO_OFF);
    assign hit_hi = (araddr == `LSU_CLINT_BASE + `LSU_MTIME_HI_OFF);

    assign arready   = !rvalid_q;
    assign rd.rvalid = rvalid_q;
    assign rd.rresp  = rerr_q ? lsu_pkg::SLVERR : lsu_pkg::OKAY;
    assign rd.rdata  = rdata_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime    <= '0;
            rvalid_q <= 1'b0;
        end else begin
            mtime    <= mtime + 64'd1;           // free running
            rvalid_q <= arvalid && arready;      // one cycle later, rready high
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            if (hit_lo) begin
                rdata_q <= mtime[31:0];
            end else if (hit_hi) begin
                rdata_q <= mtime[63:32];
            end else begin
                rdata_q <= 32'd0;
            end
            rerr_q <= !(hit_lo || hit_hi);
        end
    end

endmodule

//--- design/data_sram.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module data_sram (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             arvalid,
    input  logic [31:0]      araddr,
    output logic             arready,
    output lsu_pkg::rd_rsp_t rd,
    input  lsu_pkg::wr_req_t wr,
    output logic             awready,
    output logic             wready,
    output logic             bvalid,
    output lsu_pkg::resp_e   bresp
);

    localparam int WORDS = `LSU_SRAM_WORDS;
    localparam int IDX_W = $clog2(WORDS);
    localparam int LAT   = `LSU_SRAM_LAT;
    localparam int CNT_W = $clog2(LAT + 1);

    typedef enum logic [1:0] {W_ADDR, W_DATA, W_RESP} wphase_e;

    logic [31:0]      mem [0:WORDS-1];
    logic [CNT_W-1:0] rd_cnt;
    logic [31:0]      rdata_q;
    logic             rerr_q;
    wphase_e          wphase;
    logic [31:0]      waddr_q;
    logic             werr_q;

    function automatic logic in_range(input logic [31:0] a);
        return (a >= `LSU_SRAM_BASE) && (a < `LSU_SRAM_BASE + 32'(4 * WORDS));
    endfunction

    function automatic logic [IDX_W-1:0] word_idx(input logic [31:0] a);
        logic [31:0] off;
        off = a - `LSU_SRAM_BASE;
        return off[IDX_W+1:2];
    endfunction

    assign arready   = (rd_cnt == '0);
    assign rd.rvalid = (rd_cnt == CNT_W'(1));
    assign rd.rresp  = rerr_q ? lsu_pkg::SLVERR : lsu_pkg::OKAY;
    assign rd.rdata  = rdata_q;

    assign awready = (wphase == W_ADDR);
    assign wready  = (wphase == W_DATA);
    assign bvalid  = (wphase == W_RESP);
    assign bresp   = werr_q ? lsu_pkg::SLVERR : lsu_pkg::OKAY;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_cnt <= '0;
            wphase <= W_ADDR;
        end else begin
            if (arvalid && arready) begin
                rd_cnt <= CNT_W'(LAT);
            end else if (rd_cnt != '0) begin
                rd_cnt <= rd_cnt - 1'b1;
            end
            case (wphase)
                W_ADDR:  if (wr.awvalid) wphase <= W_DATA;
                W_DATA:  if (wr.wvalid) wphase <= W_RESP;
                default: wphase <= W_ADDR;   // bready always high
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            rdata_q <= in_range(araddr) ? mem[word_idx(araddr)] : 32'd0;
            rerr_q  <= !in_range(araddr);
        end
        if (wr.awvalid && awready) begin
            waddr_q <= wr.awaddr;
        end
        if (wr.wvalid && wready) begin
            werr_q <= !in_range(waddr_q);
            for (int b = 0; b < 4; b++) begin
                if (wr.wstrb[b] && in_range(waddr_q)) begin
                    mem[word_idx(waddr_q)][8*b +: 8] <= wr.wdata[8*b +: 8];
                end
            end
        end
    end

    a_wdata_after_addr: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr.wvalid |-> (wphase == W_DATA)
    );

endmodule

//--- design/lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// core-local timer window, inclusive
`define LSU_CLINT_BASE 32'h0200_0000
`define LSU_CLINT_END 32'h0200_FFFF

// mtime word offsets inside the timer window
`define LSU_MTIME_LO_OFF 32'h0000_BFF8
`define LSU_MTIME_HI_OFF 32'h0000_BFFC

// data SRAM placement and depth
`define LSU_SRAM_BASE 32'h8000_0000
`define LSU_SRAM_WORDS 1024

// read address accepted to read data valid
`define LSU_SRAM_LAT 2

`endif

//--- design/lsu_decode.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_decode (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    input  lsu_pkg::lsu_req_t req,
    output logic              acc_valid,
    output lsu_pkg::lsu_acc_t acc
);

    lsu_pkg::lsu_acc_t acc_d;
    logic [1:0]        lane;
    logic              to_clint;

    assign lane     = req.addr[1:0];
    assign to_clint = (req.addr >= `LSU_CLINT_BASE) && (req.addr <= `LSU_CLINT_END);

    always_comb begin
        acc_d          = '0;
        acc_d.is_load  = req.ren;
        acc_d.is_store = req.wen;
        acc_d.to_clint = to_clint;
        acc_d.reject   = req.wen && to_clint;   // timer is read only here
        acc_d.addr     = req.addr;
        acc_d.lane     = lane;
        acc_d.sign     = req.sign;
        acc_d.width    = req.width;
        acc_d.wmem     = req.wdata << {lane, 3'b000};
        case (req.width)
            lsu_pkg::BYTE: begin
                acc_d.wstrb = 4'b0001 << lane;
                acc_d.size  = 3'd0;
            end
            lsu_pkg::HALF: begin
                acc_d.wstrb = lane[1] ? 4'b1100 : 4'b0011;
                acc_d.size  = 3'd1;
            end
            lsu_pkg::WORD: begin
                acc_d.wstrb = 4'b1111;
                acc_d.size  = 3'd2;
            end
            default: begin
                acc_d.wstrb = 4'b0000;   // no bytes touched
                acc_d.size  = 3'd0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= req_valid;
        end
    end

    // held until the next accepted request
    always_ff @(posedge clk) begin
        if (req_valid) begin
            acc <= acc_d;
        end
    end

endmodule

//--- design/lsu_exec.sv
`timescale 1ns/1ps

module lsu_exec (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              acc_valid,
    input  lsu_pkg::lsu_acc_t acc,
    output logic              busy,
    output logic              sram_arvalid,
    input  logic              sram_arready,
    input  lsu_pkg::rd_rsp_t  sram_rd,
    output logic              clint_arvalid,
    input  logic              clint_arready,
    input  lsu_pkg::rd_rsp_t  clint_rd,
    output logic [31:0]       araddr,
    output lsu_pkg::wr_req_t  sram_wr,
    input  logic              awready,
    input  logic              wready,
    input  logic              bvalid,
    input  lsu_pkg::resp_e    bresp,
    output lsu_pkg::rd_rsp_t  rsp,
    output logic              rsp_take,
    output logic              done,
    output logic              bad_resp
);

    typedef enum logic [2:0] {IDLE, AR, R, AW, W, B, FIN} state_e;

    state_e state;
    state_e state_nxt;
    logic   arready_sel;

    assign arready_sel   = acc.to_clint ? clint_arready : sram_arready;
    assign rsp           = acc.to_clint ? clint_rd : sram_rd;   // same routing as ar
    assign araddr        = acc.addr;
    assign sram_arvalid  = (state == AR) && !acc.to_clint;
    assign clint_arvalid = (state == AR) && acc.to_clint;
    assign rsp_take      = (state == R) && rsp.rvalid;   // rready tied high
    assign done          = (state == FIN);
    assign busy          = acc_valid || (state != IDLE);

    // writes only ever go to the SRAM
    always_comb begin
        sram_wr.awvalid = (state == AW);
        sram_wr.wvalid  = (state == W);
        sram_wr.awaddr  = acc.addr;
        sram_wr.wdata   = acc.wmem;
        sram_wr.wstrb   = acc.wstrb;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (acc_valid) begin
                    if (acc.reject || !(acc.is_load || acc.is_store)) begin
                        state_nxt = FIN;
                    end else if (acc.is_load) begin
                        state_nxt = AR;
                    end else begin
                        state_nxt = AW;
                    end
                end
            end
            AR:      if (arready_sel) state_nxt = R;
            R:       if (rsp.rvalid) state_nxt = FIN;
            AW:      if (awready) state_nxt = W;
            W:       if (wready) state_nxt = B;
            B:       if (bvalid) state_nxt = FIN;   // bready tied high
            FIN:     state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            bad_resp <= 1'b0;
        end else begin
            state <= state_nxt;
            if ((state == IDLE) && acc_valid) begin
                bad_resp <= acc.reject;
            end else if (rsp_take) begin
                bad_resp <= (rsp.rresp != lsu_pkg::OKAY);
            end else if ((state == B) && bvalid) begin
                bad_resp <= (bresp != lsu_pkg::OKAY);
            end
        end
    end

    // core must hold off until done
    a_no_acc_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        acc_valid |-> (state == IDLE)
    );

    a_done_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |=> !done
    );

    a_single_ar_target: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(sram_arvalid && clint_arvalid)
    );

endmodule

//--- design/lsu_pkg.sv
package lsu_pkg;

    typedef enum logic [1:0] {
        NONE = 2'd0,
        BYTE = 2'd1,
        HALF = 2'd2,
        WORD = 2'd3
    } mem_width_e;

    typedef enum logic [1:0] {
        OKAY   = 2'd0,
        SLVERR = 2'd2
    } resp_e;

    typedef struct packed {
        logic        wen;
        logic        ren;
        logic        sign;
        mem_width_e  width;
        logic [31:0] addr;
        logic [31:0] wdata;
    } lsu_req_t;

    typedef struct packed {
        logic        is_load;
        logic        is_store;
        logic        to_clint;
        logic        reject;     // store aimed at the timer
        logic [31:0] addr;
        logic [2:0]  size;
        logic [3:0]  wstrb;
        logic [31:0] wmem;       // store data already on its lanes
        logic [1:0]  lane;
        logic        sign;
        mem_width_e  width;
    } lsu_acc_t;

    typedef struct packed {
        logic        rvalid;
        resp_e       rresp;
        logic [31:0] rdata;
    } rd_rsp_t;

    typedef struct packed {
        logic        awvalid;
        logic        wvalid;
        logic [31:0] awaddr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } wr_req_t;

endpackage

//--- design/lsu_result.sv
`timescale 1ns/1ps

module lsu_result (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              rsp_take,
    input  lsu_pkg::rd_rsp_t  rsp,
    input  lsu_pkg::lsu_acc_t acc,
    input  logic              done,
    input  logic              bad_resp,
    output logic [31:0]       rdata,
    output logic              err
);

    logic [31:0] word_q;
    logic [31:0] shifted;
    logic [31:0] ext;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_q <= '0;
        end else if (rsp_take) begin
            word_q <= rsp.rdata;
        end
    end

    assign shifted = word_q >> {acc.lane, 3'b000};   // addressed lane down to bit 0

    always_comb begin
        if (!acc.is_load || (acc.width == lsu_pkg::NONE)) begin
            ext = '0;   // stores return nothing
        end else begin
            case (acc.size)
                3'd0:    ext = {{24{acc.sign & shifted[7]}}, shifted[7:0]};
                3'd1:    ext = {{16{acc.sign & shifted[15]}}, shifted[15:0]};
                default: ext = shifted;
            endcase
        end
    end

    assign rdata = done ? ext : 32'd0;
    assign err   = done && bad_resp;

endmodule

//--- design/lsu_top.sv
`timescale 1ns/1ps

module lsu_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    input  lsu_pkg::lsu_req_t req,
    output logic              busy,
    output logic              done,
    output logic [31:0]       rdata,
    output logic              err
);

    logic              req_take;
    logic              acc_valid;
    lsu_pkg::lsu_acc_t acc;
    logic              sram_arvalid;
    logic              sram_arready;
    lsu_pkg::rd_rsp_t  sram_rd;
    logic              clint_arvalid;
    logic              clint_arready;
    lsu_pkg::rd_rsp_t  clint_rd;
    logic [31:0]       araddr;
    lsu_pkg::wr_req_t  sram_wr;
    logic              awready;
    logic              wready;
    logic              bvalid;
    lsu_pkg::resp_e    bresp;
    lsu_pkg::rd_rsp_t  rsp;
    logic              rsp_take;
    logic              bad_resp;

    assign req_take = req_valid && !busy;   // requests during busy are dropped

    lsu_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_take),
        .req       (req),
        .acc_valid (acc_valid),
        .acc       (acc)
    );

    lsu_exec u_exec (
        .clk           (clk),
        .rst_n         (rst_n),
        .acc_valid     (acc_valid),
        .acc           (acc),
        .busy          (busy),
        .sram_arvalid  (sram_arvalid),
        .sram_arready  (sram_arready),
        .sram_rd       (sram_rd),
        .clint_arvalid (clint_arvalid),
        .clint_arready (clint_arready),
        .clint_rd      (clint_rd),
        .araddr        (araddr),
        .sram_wr       (sram_wr),
        .awready       (awready),
        .wready        (wready),
        .bvalid        (bvalid),
        .bresp         (bresp),
        .rsp           (rsp),
        .rsp_take      (rsp_take),
        .done          (done),
        .bad_resp      (bad_resp)
    );

    lsu_result u_result (
        .clk      (clk),
        .rst_n    (rst_n),
        .rsp_take (rsp_take),
        .rsp      (rsp),
        .acc      (acc),
        .done     (done),
        .bad_resp (bad_resp),
        .rdata    (rdata),
        .err      (err)
    );

    data_sram u_sram (
        .clk     (clk),
        .rst_n   (rst_n),
        .arvalid (sram_arvalid),
        .araddr  (araddr),
        .arready (sram_arready),
        .rd      (sram_rd),
        .wr      (sram_wr),
        .awready (awready),
        .wready  (wready),
        .bvalid  (bvalid),
        .bresp   (bresp)
    );

    clint_timer u_clint (
        .clk     (clk),
        .rst_n   (rst_n),
        .arvalid (clint_arvalid),
        .araddr  (araddr),
        .arready (clint_arready),
        .rd      (clint_rd)
    );

endmodule

//--- lsu_sys.f
+incdir+design
design/lsu_pkg.sv
design/lsu_decode.sv
design/lsu_exec.sv
design/lsu_result.sv
design/data_sram.sv
design/clint_timer.sv
design/lsu_top.sv
tb/lsu_tb.sv

//--- tb/lsu_tb.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_tb;

    localparam int          NWIN     = 16;                        // SRAM words exercised
    localparam logic [31:0] WIN_BASE = `LSU_SRAM_BASE + 32'h40;
    localparam int          TIMEOUT  = 50;

    typedef struct packed {
        logic        chk_data;
        logic [31:0] rdata;
        logic        err;
    } exp_t;

    logic              clk;
    logic              rst_n;
    logic              req_valid;
    lsu_pkg::lsu_req_t req;
    logic              busy;
    logic              done;
    logic [31:0]       rdata;
    logic              err;

    logic [31:0] shadow [0:NWIN-1];
    exp_t        exp_q [$];
    exp_t        mon_exp;
    logic [31:0] rng_state;
    int          error_count;

    lsu_top u_lsu_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .done      (done),
        .rdata     (rdata),
        .err       (err)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]};
    endfunction

    // expected load value from the stored word
    function automatic logic [31:0] load_result(input logic [31:0] word, input logic [1:0] lane,
                                                input lsu_pkg::mem_width_e width,
                                                input logic sign);
        logic [31:0] sh;
        logic [31:0] res;
        sh = word >> (8 * lane);
        case (width)
            lsu_pkg::BYTE: res = sign ? {{24{sh[7]}}, sh[7:0]} : {24'd0, sh[7:0]};
            lsu_pkg::HALF: res = sign ? {{16{sh[15]}}, sh[15:0]} : {16'd0, sh[15:0]};
            default:       res = word;
        endcase
        return res;
    endfunction

    function automatic logic [31:0] merge_store(input logic [31:0] old, input logic [31:0] data,
                                                input logic [1:0] lane,
                                                input lsu_pkg::mem_width_e width);
        logic [31:0] res;
        res = old;
        case (width)
            lsu_pkg::BYTE: res[8*lane +: 8] = data[7:0];
            lsu_pkg::HALF: res[8*lane +: 16] = data[15:0];
            lsu_pkg::WORD: res = data;
            default:       res = old;
        endcase
        return res;
    endfunction

    function automatic lsu_pkg::lsu_req_t make_req(input logic wen, input logic sign,
                                                   input lsu_pkg::mem_width_e width,
                                                   input logic [31:0] addr,
                                                   input logic [31:0] wdata);
        lsu_pkg::lsu_req_t r;
        r.wen   = wen;
        r.ren   = !wen;
        r.sign  = sign;
        r.width = width;
        r.addr  = addr;
        r.wdata = wdata;
        return r;
    endfunction

    function automatic exp_t expect_entry(input logic chk, input logic [31:0] data,
                                          input logic e);
        exp_t x;
        x.chk_data = chk;
        x.rdata    = data;
        x.err      = e;
        return x;
    endfunction

    task automatic next_rand(output logic [31:0] v);
        rng_state = lcg_step(rng_state);
        v = rng_state;
    endtask

    task automatic stop_run(input string msg);
        error_count++;
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] t=%0t %s got=%h expected=%h", $time, name, got, exp);
            $display("Finished with errors");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic send_req(input lsu_pkg::lsu_req_t r);
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= r;
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    // busy must hold until done shows up
    task automatic wait_done(output logic [31:0] got);
        int n;
        n = 0;
        @(negedge clk);
        while (!done) begin
            check("busy", busy, 1'b1);
            n++;
            if (n >= TIMEOUT) stop_run("timed out waiting for done from the LSU");
            @(negedge clk);
        end
        check("busy", busy, 1'b1);
        got = rdata;
    endtask

    task automatic run_op(input lsu_pkg::lsu_req_t r, input exp_t e, output logic [31:0] got);
        exp_q.push_back(e);
        send_req(r);
        wait_done(got);
    endtask

    task automatic sram_store(input int idx, input logic [1:0] lane,
                              input lsu_pkg::mem_width_e width, input logic [31:0] data);
        logic [31:0] got;
        shadow[idx] = merge_store(shadow[idx], data, lane, width);
        run_op(make_req(1'b1, 1'b0, width, WIN_BASE + 32'(4 * idx) + lane, data),
               expect_entry(1'b1, 32'd0, 1'b0), got);
    endtask

    task automatic sram_load(input int idx, input logic [1:0] lane,
                             input lsu_pkg::mem_width_e width, input logic sign);
        logic [31:0] got;
        run_op(make_req(1'b0, sign, width, WIN_BASE + 32'(4 * idx) + lane, 32'd0),
               expect_entry(1'b1, load_result(shadow[idx], lane, width, sign), 1'b0), got);
    endtask

    task automatic expect_quiet(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (done) stop_run("extra done pulse after a request sent while busy");
        end
    endtask

    // compares every done against the oldest expectation
    always @(negedge clk) begin
        if (rst_n && done) begin
            if (exp_q.size() == 0) begin
                stop_run("done pulse with no request outstanding");
            end else begin
                mon_exp = exp_q.pop_front();
                if (mon_exp.chk_data) check("rdata", rdata, mon_exp.rdata);
                check("err", err, mon_exp.err);
            end
        end
    end

    initial begin
        logic [31:0]         v;
        logic [31:0]         d;
        logic [31:0]         got;
        logic [31:0]         t0;
        logic [31:0]         t1;
        int                  idx;
        logic [1:0]          lane;
        lsu_pkg::mem_width_e w;
        rst_n       = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        rng_state   = 32'h4c2e;
        error_count = 0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check("done", done, 1'b0);
        check("busy", busy, 1'b0);
        check("err", err, 1'b0);

        for (int i = 0; i < NWIN; i++) sram_store(i, 2'd0, lsu_pkg::WORD,
                                                  fill_word(WIN_BASE + 32'(4 * i)));
        for (int i = 0; i < NWIN; i++) sram_load(i, 2'd0, lsu_pkg::WORD, 1'b0);

        sram_store(1, 2'd2, lsu_pkg::BYTE, 32'h1234_56A5);   // upper bytes must not land
        sram_load(1, 2'd0, lsu_pkg::WORD, 1'b0);
        sram_store(2, 2'd0, lsu_pkg::HALF, 32'hFFFF_8001);
        sram_store(2, 2'd2, lsu_pkg::HALF, 32'h0000_7E5A);
        sram_load(2, 2'd0, lsu_pkg::WORD, 1'b0);
        sram_store(5, 2'd3, lsu_pkg::BYTE, 32'h0000_00C3);
        sram_load(5, 2'd0, lsu_pkg::WORD, 1'b0);

        sram_store(6, 2'd0, lsu_pkg::WORD, 32'h80FF_7F81);   // mixed lane sign bits
        for (int l = 0; l < 4; l++) begin
            sram_load(6, 2'(l), lsu_pkg::BYTE, 1'b0);
            sram_load(6, 2'(l), lsu_pkg::BYTE, 1'b1);
        end
        for (int l = 0; l < 4; l += 2) begin
            sram_load(6, 2'(l), lsu_pkg::HALF, 1'b0);
            sram_load(6, 2'(l), lsu_pkg::HALF, 1'b1);
        end

        for (int n = 0; n < 200; n++) begin
            next_rand(v);
            next_rand(d);
            idx = int'(v[19:16]);
            case (v[21:20])
                2'd1:    w = lsu_pkg::HALF;
                2'd2:    w = lsu_pkg::WORD;
                default: w = lsu_pkg::BYTE;
            endcase
            if (w == lsu_pkg::BYTE) begin
                lane = v[23:22];
            end else if (w == lsu_pkg::HALF) begin
                lane = {v[23], 1'b0};
            end else begin
                lane = 2'd0;
            end
            if (v[24]) begin
                sram_store(idx, lane, w, d);
            end else begin
                sram_load(idx, lane, w, v[25]);
            end
        end

        run_op(make_req(1'b0, 1'b0, lsu_pkg::WORD, `LSU_CLINT_BASE + `LSU_MTIME_LO_OFF, 32'd0),
               expect_entry(1'b0, 32'd0, 1'b0), t0);
        repeat (20) @(posedge clk);
        run_op(make_req(1'b0, 1'b0, lsu_pkg::WORD, `LSU_CLINT_BASE + `LSU_MTIME_LO_OFF, 32'd0),
               expect_entry(1'b0, 32'd0, 1'b0), t1);
        check("mtime_lo_increasing", t1 > t0, 1'b1);
        run_op(make_req(1'b0, 1'b0, lsu_pkg::WORD, `LSU_CLINT_BASE + `LSU_MTIME_HI_OFF, 32'd0),
               expect_entry(1'b1, 32'd0, 1'b0), got);

        run_op(make_req(1'b1, 1'b0, lsu_pkg::WORD, `LSU_CLINT_BASE + 32'h10, 32'hFFFF_FFFF),
               expect_entry(1'b1, 32'd0, 1'b1), got);
        for (int i = 0; i < NWIN; i++) sram_load(i, 2'd0, lsu_pkg::WORD, 1'b0);
        run_op(make_req(1'b0, 1'b0, lsu_pkg::WORD, 32'h4000_0000, 32'd0),
               expect_entry(1'b1, 32'd0, 1'b1), got);

        // a store pulsed mid-load has to be dropped
        exp_q.push_back(expect_entry(1'b1, shadow[3], 1'b0));
        send_req(make_req(1'b0, 1'b0, lsu_pkg::WORD, WIN_BASE + 32'd12, 32'd0));
        @(negedge clk);
        check("busy", busy, 1'b1);
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= make_req(1'b1, 1'b0, lsu_pkg::WORD, WIN_BASE + 32'd12, 32'hDEAD_BEEF);
        @(posedge clk);
        req_valid <= 1'b0;
        wait_done(got);
        expect_quiet(TIMEOUT);
        sram_load(3, 2'd0, lsu_pkg::WORD, 1'b0);

        @(posedge clk);
        check("pending_expectations", exp_q.size(), 32'd0);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
